// ==== Makefile ====
# Verilator build and run of the SURF link testbench

VERILATOR ?= verilator
TOP       ?= surf_link_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION PASSED" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/surf_link_pkg.sv ====
package surf_link_pkg;

    // seven digitizer boards hang off the trigger board
    localparam int NUM_SURF = 7;

    // COUT is the SURF to trigger board command/status lane group
    localparam int COUT_W = 4;

    // DOUT is the SURF data lane group
    localparam int DOUT_W = 8;

    // the register port only decodes four words
    localparam int REG_ADR_W = 2;

    // autostart enable mask, one bit per SURF, writable
    localparam logic [REG_ADR_W-1:0] REG_CTRL_ADR = 2'd0;

    // train complete force mask, one bit per SURF, writable
    localparam logic [REG_ADR_W-1:0] REG_FORCE_ADR = 2'd1;

    // live status, read only
    localparam logic [REG_ADR_W-1:0] REG_LIVE_ADR = 2'd2;

    // training status, read only
    // request bits sit in the low half and ready bits in the high half
    localparam logic [REG_ADR_W-1:0] REG_TRAIN_ADR = 2'd3;

    // what the autostart controller is doing for one SURF
    // AS_IDLE waits for a training request
    // AS_TRAIN_CIN drives CIN training and waits for the SURF output pattern
    // AS_LOCK_WAIT gives the output path time to lock
    // AS_DONE holds train complete until the request goes away
    typedef enum logic [1:0] {
        AS_IDLE      = 2'd0,
        AS_TRAIN_CIN = 2'd1,
        AS_LOCK_WAIT = 2'd2,
        AS_DONE      = 2'd3
    } autostart_state_t;

endpackage

// ==== source/surf_autostart_ctrl.sv ====
// autostart sequencing, one state machine per SURF in the register clock
// a SURF asks for CIN training by dropping DOUT, we answer by turning on cin_train
// once the SURF puts COUT into training the output path gets LOCK_CYCLES to lock,
// then train complete is raised and held so the detector can call the link live
// software can keep a SURF out of autostart with the enable mask
// the force mask skips the lock wait and answers train complete right away
module surf_autostart_ctrl #(
    parameter int LOCK_CYCLES = 8
) (
    input  logic                                wb_clk_i,
    input  logic                                wb_reset_i,
    // synchronized status from the live detector
    input  logic [surf_link_pkg::NUM_SURF-1:0] train_in_req_i,
    input  logic [surf_link_pkg::NUM_SURF-1:0] train_out_rdy_i,
    // masks from the register block
    input  logic [surf_link_pkg::NUM_SURF-1:0] autostart_en_i,
    input  logic [surf_link_pkg::NUM_SURF-1:0] force_complete_i,
    output logic [surf_link_pkg::NUM_SURF-1:0] cin_train_o,
    output logic [surf_link_pkg::NUM_SURF-1:0] train_complete_o
);

    import surf_link_pkg::*;

    // counter only has to reach LOCK_CYCLES-1
    localparam int LOCK_W = (LOCK_CYCLES > 2) ? $clog2(LOCK_CYCLES) : 1;
    localparam logic [LOCK_W-1:0] LOCK_LAST = LOCK_W'(LOCK_CYCLES - 1);

    // with a single lock cycle there is nothing to wait for
    localparam bit NO_LOCK_WAIT = (LOCK_CYCLES <= 1);

    for (genvar s = 0; s < NUM_SURF; s++) begin : g_surf
        autostart_state_t  state;
        logic [LOCK_W-1:0] lock_cnt;
        logic              cin_train;
        logic              complete;

        always_ff @(posedge wb_clk_i) begin
            if (wb_reset_i) begin
                state     <= AS_IDLE;
                lock_cnt  <= '0;
                cin_train <= 1'b0;
                complete  <= 1'b0;
            end else if (state != AS_IDLE && !train_in_req_i[s]) begin
                // request gone means the SURF rebooted or was lost, start over
                state     <= AS_IDLE;
                lock_cnt  <= '0;
                cin_train <= 1'b0;
                complete  <= 1'b0;
            end else begin
                case (state)
                    AS_IDLE: begin
                        if (train_in_req_i[s] && autostart_en_i[s]) begin
                            state     <= AS_TRAIN_CIN;
                            cin_train <= 1'b1;
                        end
                    end
                    AS_TRAIN_CIN: begin
                        // the edge that sees ready is the first lock cycle
                        if (train_out_rdy_i[s]) begin
                            if (force_complete_i[s] || NO_LOCK_WAIT) begin
                                state    <= AS_DONE;
                                complete <= 1'b1;
                            end else begin
                                state    <= AS_LOCK_WAIT;
                                lock_cnt <= LOCK_W'(1);
                            end
                        end
                    end
                    AS_LOCK_WAIT: begin
                        // force set during the wait also cuts it short
                        if (lock_cnt == LOCK_LAST || force_complete_i[s]) begin
                            state    <= AS_DONE;
                            complete <= 1'b1;
                        end else begin
                            lock_cnt <= lock_cnt + 1'b1;
                        end
                    end
                    AS_DONE: begin
                        // hold train complete and CIN training until the request drops
                        lock_cnt <= '0;
                    end
                    default: begin
                        state <= AS_IDLE;
                    end
                endcase
            end
        end

        assign cin_train_o[s]      = cin_train;
        assign train_complete_o[s] = complete;
    end

endmodule

// ==== source/surf_link_regs.sv ====
// control and status registers for the SURF link bring-up
// the port is a bare write strobe and a read strobe, with read data
// and a one-cycle valid pulse coming back on the next wb cycle
module surf_link_regs (
    input  logic                                  wb_clk_i,
    input  logic                                  wb_reset_i,
    input  logic                                  reg_wr_i,
    input  logic                                  reg_rd_i,
    input  logic [surf_link_pkg::REG_ADR_W-1:0]   reg_adr_i,
    input  logic [2*surf_link_pkg::NUM_SURF-1:0]  reg_wdata_i,
    // synchronized status from the live detector
    input  logic [surf_link_pkg::NUM_SURF-1:0]    live_i,
    input  logic [surf_link_pkg::NUM_SURF-1:0]    train_in_req_i,
    input  logic [surf_link_pkg::NUM_SURF-1:0]    train_out_rdy_i,
    output logic [2*surf_link_pkg::NUM_SURF-1:0]  reg_rdata_o,
    output logic                                  reg_rvalid_o,
    output logic [surf_link_pkg::NUM_SURF-1:0]    autostart_en_o,
    output logic [surf_link_pkg::NUM_SURF-1:0]    force_complete_o
);

    import surf_link_pkg::*;

    logic [2*NUM_SURF-1:0] rd_word;

    // autostart is on for every SURF out of reset, nothing is forced
    always_ff @(posedge wb_clk_i) begin
        if (wb_reset_i) begin
            autostart_en_o   <= {NUM_SURF{1'b1}};
            force_complete_o <= {NUM_SURF{1'b0}};
        end else if (reg_wr_i) begin
            // only the low half of the write data holds mask bits
            // status words are read only, so writes there fall through
            case (reg_adr_i)
                REG_CTRL_ADR:  autostart_en_o   <= reg_wdata_i[NUM_SURF-1:0];
                REG_FORCE_ADR: force_complete_o <= reg_wdata_i[NUM_SURF-1:0];
                default: begin
                end
            endcase
        end
    end

    // word selected by the current address
    always_comb begin
        case (reg_adr_i)
            REG_CTRL_ADR:  rd_word = {{NUM_SURF{1'b0}}, autostart_en_o};
            REG_FORCE_ADR: rd_word = {{NUM_SURF{1'b0}}, force_complete_o};
            REG_LIVE_ADR:  rd_word = {{NUM_SURF{1'b0}}, live_i};
            default:       rd_word = {train_out_rdy_i, train_in_req_i};
        endcase
    end

    // read data is captured on the strobe and stays until the next read
    always_ff @(posedge wb_clk_i) begin
        if (reg_rd_i) begin
            reg_rdata_o <= rd_word;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_reset_i) begin
            reg_rvalid_o <= 1'b0;
        end else begin
            reg_rvalid_o <= reg_rd_i;
        end
    end

endmodule

// ==== source/surf_link_top.sv ====
// SURF link bring-up top level
// the detector runs on the lane clock, control and registers on the wb clock,
// and every level between them crosses through a two-flop synchronizer
module surf_link_top #(
    parameter int COUT_LOSS_BITS = 4,
    parameter int LOCK_CYCLES    = 8
) (
    input  logic                                                    sys_clk_i,
    input  logic                                                    wb_clk_i,
    input  logic                                                    reset_i,
    input  logic [surf_link_pkg::NUM_SURF*surf_link_pkg::COUT_W-1:0] cout_i,
    input  logic [surf_link_pkg::NUM_SURF*surf_link_pkg::DOUT_W-1:0] dout_i,
    input  logic                                                    reg_wr_i,
    input  logic                                                    reg_rd_i,
    input  logic [surf_link_pkg::REG_ADR_W-1:0]                     reg_adr_i,
    input  logic [2*surf_link_pkg::NUM_SURF-1:0]                    reg_wdata_i,
    output logic [2*surf_link_pkg::NUM_SURF-1:0]                    reg_rdata_o,
    output logic                                                    reg_rvalid_o,
    output logic [surf_link_pkg::NUM_SURF-1:0]                      cin_train_o,
    output logic [surf_link_pkg::NUM_SURF-1:0]                      surf_live_o
);

    import surf_link_pkg::*;

    // status in the lane clock
    logic [NUM_SURF-1:0] train_in_req_sys;
    logic [NUM_SURF-1:0] train_out_rdy_sys;
    logic [NUM_SURF-1:0] surf_live_sys;
    // the same status seen from the wb clock
    logic [NUM_SURF-1:0] train_in_req_wb;
    logic [NUM_SURF-1:0] train_out_rdy_wb;
    logic                wb_reset;
    // controller outputs and register masks
    logic [NUM_SURF-1:0] train_complete_wb;
    logic [NUM_SURF-1:0] train_complete_sys;
    logic [NUM_SURF-1:0] autostart_en;
    logic [NUM_SURF-1:0] force_complete;

    surf_live_detector #(
        .COUT_LOSS_BITS(COUT_LOSS_BITS)
    ) u_detector (
        .sys_clk_i       (sys_clk_i),
        .reset_i         (reset_i),
        .cout_i          (cout_i),
        .dout_i          (dout_i),
        .train_complete_i(train_complete_sys),
        .train_in_req_o  (train_in_req_sys),
        .train_out_rdy_o (train_out_rdy_sys),
        .surf_live_o     (surf_live_sys)
    );

    // all detector status moves into the wb clock through one bank
    surf_status_sync #(
        .SYNC_W(3*NUM_SURF)
    ) u_status_sync (
        .dst_clk_i(wb_clk_i),
        .d_i      ({surf_live_sys, train_out_rdy_sys, train_in_req_sys}),
        .q_o      ({surf_live_o, train_out_rdy_wb, train_in_req_wb})
    );

    // register side reset is a resynchronized copy of the lane side reset
    surf_status_sync #(
        .SYNC_W(1)
    ) u_reset_sync (
        .dst_clk_i(wb_clk_i),
        .d_i      (reset_i),
        .q_o      (wb_reset)
    );

    // train complete goes back to the detector in the lane clock
    surf_status_sync #(
        .SYNC_W(NUM_SURF)
    ) u_complete_sync (
        .dst_clk_i(sys_clk_i),
        .d_i      (train_complete_wb),
        .q_o      (train_complete_sys)
    );

    surf_autostart_ctrl #(
        .LOCK_CYCLES(LOCK_CYCLES)
    ) u_autostart (
        .wb_clk_i        (wb_clk_i),
        .wb_reset_i      (wb_reset),
        .train_in_req_i  (train_in_req_wb),
        .train_out_rdy_i (train_out_rdy_wb),
        .autostart_en_i  (autostart_en),
        .force_complete_i(force_complete),
        .cin_train_o     (cin_train_o),
        .train_complete_o(train_complete_wb)
    );

    surf_link_regs u_regs (
        .wb_clk_i        (wb_clk_i),
        .wb_reset_i      (wb_reset),
        .reg_wr_i        (reg_wr_i),
        .reg_rd_i        (reg_rd_i),
        .reg_adr_i       (reg_adr_i),
        .reg_wdata_i     (reg_wdata_i),
        .live_i          (surf_live_o),
        .train_in_req_i  (train_in_req_wb),
        .train_out_rdy_i (train_out_rdy_wb),
        .reg_rdata_o     (reg_rdata_o),
        .reg_rvalid_o    (reg_rvalid_o),
        .autostart_en_o  (autostart_en),
        .force_complete_o(force_complete)
    );

endmodule

// ==== surf_live/surf_live_detector.sv ====
// tracks the link state of every SURF from its COUT and DOUT lanes
// a SURF powers up long after the trigger board, so every SURF starts out not live
// DOUT all zero after boot means the SURF has clocks and asks for CIN training
// COUT all zero while that request stands means its outputs are in training
// a long run of all-ones COUT means the board rebooted or the link went away
// COUT is used for loss because DOUT may carry anything once the link is up
module surf_live_detector #(
    parameter int COUT_LOSS_BITS = 4
) (
    input  logic                                                   sys_clk_i,
    input  logic                                                   reset_i,
    // all COUT lanes, SURF s occupies bits [4*s +: 4]
    input  logic [surf_link_pkg::NUM_SURF*surf_link_pkg::COUT_W-1:0] cout_i,
    // all DOUT lanes, SURF s occupies bits [8*s +: 8]
    input  logic [surf_link_pkg::NUM_SURF*surf_link_pkg::DOUT_W-1:0] dout_i,
    // train complete from the autostart controller, already back in sys_clk_i
    input  logic [surf_link_pkg::NUM_SURF-1:0]                       train_complete_i,
    output logic [surf_link_pkg::NUM_SURF-1:0]                       train_in_req_o,
    output logic [surf_link_pkg::NUM_SURF-1:0]                       train_out_rdy_o,
    output logic [surf_link_pkg::NUM_SURF-1:0]                       surf_live_o
);

    import surf_link_pkg::*;

    for (genvar s = 0; s < NUM_SURF; s++) begin : g_surf
        // the top bit of the counter is the loss flag, the rest counts samples
        logic [COUT_LOSS_BITS:0] loss_cnt;
        logic                    loss;
        logic                    boot_seen;
        logic                    in_req;
        logic                    out_rdy;
        logic                    live;
        logic                    cout_ones;
        logic                    cout_zeros;
        logic                    dout_zeros;

        assign cout_ones  = (cout_i[COUT_W*s +: COUT_W] == {COUT_W{1'b1}});
        assign cout_zeros = (cout_i[COUT_W*s +: COUT_W] == {COUT_W{1'b0}});
        assign dout_zeros = (dout_i[DOUT_W*s +: DOUT_W] == {DOUT_W{1'b0}});

        // loss fires on the edge after the last of 2^COUT_LOSS_BITS all-ones samples
        assign loss = loss_cnt[COUT_LOSS_BITS];

        always_ff @(posedge sys_clk_i) begin
            if (reset_i) begin
                loss_cnt  <= '0;
                boot_seen <= 1'b0;
                in_req    <= 1'b0;
                out_rdy   <= 1'b0;
                live      <= 1'b0;
            end else begin
                // only count while the link is up or before the SURF first showed up
                // a SURF in the middle of training may legitimately idle COUT high
                if ((live || !boot_seen) && cout_ones) begin
                    loss_cnt <= {1'b0, loss_cnt[COUT_LOSS_BITS-1:0]} + 1'b1;
                end else begin
                    loss_cnt <= '0;
                end

                // boot seen is sticky, a later loss just sets it again
                if (loss) begin
                    boot_seen <= 1'b1;
                end

                // the training request needs boot, otherwise DOUT zero at power up
                // would look like a request
                if (loss) begin
                    in_req <= 1'b0;
                end else if (boot_seen && dout_zeros) begin
                    in_req <= 1'b1;
                end

                // output training pattern only counts once CIN training was asked for
                if (loss) begin
                    out_rdy <= 1'b0;
                end else if (in_req && cout_zeros) begin
                    out_rdy <= 1'b1;
                end

                // live needs our side locked as well, which train complete tells us
                if (loss) begin
                    live <= 1'b0;
                end else if (out_rdy && train_complete_i[s]) begin
                    live <= 1'b1;
                end
            end
        end

        assign train_in_req_o[s]  = in_req;
        assign train_out_rdy_o[s] = out_rdy;
        assign surf_live_o[s]     = live;
    end

endmodule

// ==== surf_live/surf_status_sync.sv ====
// two-flop synchronizer bank into the destination clock
// every bit is an independent slow level, so bits may land a cycle apart
// from each other and nothing downstream relies on them moving together
// there is no reset here, which lets the same block carry a reset across
module surf_status_sync #(
    parameter int SYNC_W = 1
) (
    input  logic              dst_clk_i,
    // source domain levels, held for many destination cycles
    input  logic [SYNC_W-1:0] d_i,
    // synchronized copy, two destination cycles late
    output logic [SYNC_W-1:0] q_o
);

    // first stage may go metastable and gets a full cycle to settle
    (* ASYNC_REG = "TRUE" *)
    logic [SYNC_W-1:0] meta_q;

    // second stage is the one the destination logic sees
    (* ASYNC_REG = "TRUE" *)
    logic [SYNC_W-1:0] sync_q;

    always_ff @(posedge dst_clk_i) begin
        meta_q <= d_i;
        sync_q <= meta_q;
    end

    assign q_o = sync_q;

endmodule

// ==== verif/surf_link_tb.sv ====
module surf_link_tb;

    import surf_link_pkg::*;

    localparam int LOSS_BITS = 4;
    localparam int LOCK = 8;
    localparam int BOOT_RUN = 2 ** LOSS_BITS;
    localparam logic [7:0] BOOT_LEN = 8'(BOOT_RUN);
    localparam int WAIT_LIMIT = 200;
    localparam int POLL_LIMIT = 80;
    localparam int SEL_CIN = 0;
    localparam int SEL_LIVE = 1;
    localparam logic [31:0] RNG_SEED = 32'h28f37dc4;
    // idle SURFs never show all ones, so they never count as booted
    localparam logic [COUT_W-1:0] IDLE_COUT = 4'hA;
    localparam logic [COUT_W-1:0] TRAIN_COUT = 4'h5;
    localparam logic [DOUT_W-1:0] BUSY_DOUT = 8'h5A;

    // one scenario row per SURF
    // the expected bits hold for the row's SURF once the row is done
    typedef struct packed {
        logic [2:0] surf;
        logic [6:0] ctrl_mask;
        logic [6:0] force_mask;
        logic [7:0] boot_len;
        logic [7:0] dout_pat;
        logic       exp_req;
        logic       exp_cin;
        logic       exp_rdy;
        logic       exp_live;
        logic       kill;
    } scen_t;

    localparam int NUM_ROWS = 5;
    localparam scen_t SCENARIOS [NUM_ROWS] = '{
        // no boot run, so DOUT zero must not count as a request
        '{3'd0, 7'h7f, 7'h00, 8'd0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        // plain autostart through the lock wait
        '{3'd1, 7'h7f, 7'h00, BOOT_LEN, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        // forced train complete skips the lock wait
        '{3'd2, 7'h7f, 7'h04, BOOT_LEN, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        // with autostart masked off the SURF trains its outputs but is never answered
        '{3'd3, 7'h77, 7'h00, BOOT_LEN, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0},
        // full bring-up and then the link is lost again
        '{3'd4, 7'h77, 7'h00, BOOT_LEN, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1}
    };

    logic                          sys_clk_i;
    logic                          wb_clk_i;
    logic                          reset_i;
    logic [NUM_SURF*COUT_W-1:0]    cout_i;
    logic [NUM_SURF*DOUT_W-1:0]    dout_i;
    logic                          reg_wr_i;
    logic                          reg_rd_i;
    logic [REG_ADR_W-1:0]          reg_adr_i;
    logic [2*NUM_SURF-1:0]         reg_wdata_i;
    logic [2*NUM_SURF-1:0]         reg_rdata_o;
    logic                          reg_rvalid_o;
    logic [NUM_SURF-1:0]           cin_train_o;
    logic [NUM_SURF-1:0]           surf_live_o;

    // lane patterns of the SURFs a row has taken over while the rest get noise
    logic [COUT_W-1:0]             lane_cout [NUM_SURF];
    logic [DOUT_W-1:0]             lane_dout [NUM_SURF];
    logic [NUM_SURF-1:0]           lane_active;
    logic [NUM_SURF-1:0]           exp_req;
    logic [NUM_SURF-1:0]           exp_rdy;
    logic [NUM_SURF-1:0]           exp_cin;
    logic [NUM_SURF-1:0]           exp_live;

    surf_link_top #(
        .COUT_LOSS_BITS(LOSS_BITS),
        .LOCK_CYCLES   (LOCK)
    ) dut0 (.*);

    initial begin
        sys_clk_i = 1'b0;
        forever #5 sys_clk_i = ~sys_clk_i;
    end

    // the one unit offset keeps wb edges off the sys edges
    initial begin
        wb_clk_i = 1'b0;
        #1;
        forever #7 wb_clk_i = ~wb_clk_i;
    end

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR time=%0t signal=%s expected=0x%0h actual=0x%0h",
                     $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    // advance the lane clock and drive all lanes just after each edge
    task automatic sys_tick(input int n);
        logic [DOUT_W-1:0] noise;
        int s;
        repeat (n) begin
            @(posedge sys_clk_i);
            #1;
            for (s = 0; s < NUM_SURF; s++) begin
                noise = DOUT_W'($urandom);
                if (noise == '0) begin
                    noise = 8'h01;
                end
                cout_i[COUT_W*s +: COUT_W] = lane_active[s] ? lane_cout[s] : IDLE_COUT;
                dout_i[DOUT_W*s +: DOUT_W] = lane_active[s] ? lane_dout[s] : noise;
            end
        end
    endtask

    task automatic wb_tick(input int n);
        repeat (n) begin
            @(posedge wb_clk_i);
            #1;
        end
    endtask

    task automatic reg_write(input logic [REG_ADR_W-1:0] adr, input logic [13:0] data);
        wb_tick(1);
        reg_wr_i = 1'b1;
        reg_adr_i = adr;
        reg_wdata_i = data;
        wb_tick(1);
        reg_wr_i = 1'b0;
    endtask

    // the valid pulse must come exactly one wb cycle after the strobe
    task automatic reg_read(input logic [REG_ADR_W-1:0] adr, output logic [13:0] data);
        wb_tick(1);
        expect_value("reg_rvalid_o", 32'd0, 32'(reg_rvalid_o));
        reg_rd_i = 1'b1;
        reg_adr_i = adr;
        wb_tick(1);
        reg_rd_i = 1'b0;
        expect_value("reg_rvalid_o", 32'd1, 32'(reg_rvalid_o));
        data = reg_rdata_o;
        wb_tick(1);
        expect_value("reg_rvalid_o", 32'd0, 32'(reg_rvalid_o));
    endtask

    function automatic logic port_bit(input int sel, input int s);
        if (sel == SEL_CIN) begin
            return cin_train_o[s];
        end
        return surf_live_o[s];
    endfunction

    // wait in wb cycles until an output bit reaches a level
    task automatic wait_port(input int sel, input int s, input logic val,
                             input string what, output int cycles);
        cycles = 0;
        while (port_bit(sel, s) !== val) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("TIMEOUT at time %0t: %s never happened for SURF %0d", $time, what, s);
                stop_on_failure();
            end
            wb_tick(1);
            cycles++;
        end
    endtask

    // an output bit that should stay low is watched for a while
    task automatic watch_low(input int sel, input int s, input int n, input string name);
        repeat (n) begin
            wb_tick(1);
            expect_value(name, 32'd0, 32'(port_bit(sel, s)));
        end
    endtask

    // poll a training register bit until it rises, or check that it stays clear
    task automatic expect_train_bit(input int b, input logic exp, input string what);
        logic [13:0] data;
        int n;
        n = 0;
        if (!exp) begin
            sys_tick(2 * BOOT_RUN);
        end
        reg_read(REG_TRAIN_ADR, data);
        while (exp && data[b] !== 1'b1) begin
            if (n >= POLL_LIMIT) begin
                $display("TIMEOUT at time %0t: %s never showed in the training register",
                         $time, what);
                stop_on_failure();
            end
            reg_read(REG_TRAIN_ADR, data);
            n++;
        end
        expect_value(what, 32'(exp), 32'(data[b]));
    endtask

    task automatic run_row(input scen_t row, input int idx);
        logic [13:0] data;
        int s;
        int cycles;
        int elapsed;
        logic lock_ok;
        autostart_state_t st;
        s = int'(row.surf);
        reg_write(REG_CTRL_ADR, {7'b0, row.ctrl_mask});
        reg_write(REG_FORCE_ADR, {7'b0, row.force_mask});
        reg_read(REG_CTRL_ADR, data);
        expect_value("reg_rdata_o", 32'({7'b0, row.ctrl_mask}), 32'(data));
        reg_read(REG_FORCE_ADR, data);
        expect_value("reg_rdata_o", 32'({7'b0, row.force_mask}), 32'(data));
        lane_active[s] = 1'b1;
        lane_cout[s] = 4'hF;
        lane_dout[s] = BUSY_DOUT;
        sys_tick(int'(row.boot_len));
        lane_cout[s] = TRAIN_COUT;
        lane_dout[s] = row.dout_pat;
        sys_tick(1);
        expect_train_bit(s, row.exp_req, "training request bit");
        if (row.exp_cin) begin
            wait_port(SEL_CIN, s, 1'b1, "cin_train_o rise", cycles);
        end else begin
            watch_low(SEL_CIN, s, 2 * LOCK, "cin_train_o");
        end
        // the SURF answers CIN training with its all-zero output pattern
        lane_cout[s] = 4'h0;
        sys_tick(1);
        expect_train_bit(NUM_SURF + s, row.exp_rdy, "training ready bit");
        if (row.exp_live) begin
            wait_port(SEL_LIVE, s, 1'b1, "surf_live_o rise", cycles);
            // counted from the edge that captured the ready bit
            elapsed = cycles + 1;
            lock_ok = row.force_mask[s] ? (elapsed < LOCK) : (elapsed >= LOCK);
            assert (lock_ok) else begin
                $display("ERROR time=%0t signal=surf_live_o lock=%0d forced=%0d elapsed=%0d",
                         $time, LOCK, row.force_mask[s], elapsed);
                stop_on_failure();
            end
        end else begin
            watch_low(SEL_LIVE, s, 4 * LOCK, "surf_live_o");
        end
        if (row.kill) begin
            // a rebooting SURF idles COUT high and DOUT no longer asks for training
            lane_cout[s] = 4'hF;
            lane_dout[s] = BUSY_DOUT;
            sys_tick(BOOT_RUN);
            wait_port(SEL_LIVE, s, 1'b0, "surf_live_o fall after loss", cycles);
            wait_port(SEL_CIN, s, 1'b0, "cin_train_o fall after loss", cycles);
        end
        exp_req[s] = row.exp_req && !row.kill;
        exp_rdy[s] = row.exp_rdy && !row.kill;
        exp_cin[s] = row.exp_cin && !row.kill;
        exp_live[s] = row.exp_live && !row.kill;
        // the full words also show that no other SURF moved
        expect_value("surf_live_o", 32'(exp_live), 32'(surf_live_o));
        expect_value("cin_train_o", 32'(exp_cin), 32'(cin_train_o));
        reg_read(REG_LIVE_ADR, data);
        expect_value("reg_rdata_o", 32'({7'b0, exp_live}), 32'(data));
        reg_read(REG_TRAIN_ADR, data);
        expect_value("reg_rdata_o", 32'({exp_rdy, exp_req}), 32'(data));
        st = !exp_cin[s] ? AS_IDLE : (exp_live[s] ? AS_DONE : AS_TRAIN_CIN);
        $display("row %0d: SURF %0d done, controller should sit in %s", idx, s, st.name());
    endtask

    initial begin
        logic [13:0] data;
        int row;
        void'($urandom(RNG_SEED));
        reset_i = 1'b1;
        cout_i = {NUM_SURF{IDLE_COUT}};
        dout_i = {NUM_SURF{BUSY_DOUT}};
        reg_wr_i = 1'b0;
        reg_rd_i = 1'b0;
        reg_adr_i = '0;
        reg_wdata_i = '0;
        lane_active = '0;
        exp_req = '0;
        exp_rdy = '0;
        exp_cin = '0;
        exp_live = '0;
        for (row = 0; row < NUM_SURF; row++) begin
            lane_cout[row] = IDLE_COUT;
            lane_dout[row] = BUSY_DOUT;
        end
        sys_tick(3);
        reset_i = 1'b0;
        // the register side reset trails by the two synchronizer stages
        wb_tick(4);
        expect_value("surf_live_o", 32'd0, 32'(surf_live_o));
        expect_value("cin_train_o", 32'd0, 32'(cin_train_o));
        expect_value("reg_rvalid_o", 32'd0, 32'(reg_rvalid_o));
        reg_read(REG_CTRL_ADR, data);
        expect_value("reg_rdata_o", 32'h7f, 32'(data));
        reg_read(REG_FORCE_ADR, data);
        expect_value("reg_rdata_o", 32'd0, 32'(data));
        // status words are read only and writes there leave both masks alone
        reg_write(REG_LIVE_ADR, 14'h3fff);
        reg_write(REG_TRAIN_ADR, 14'h3fff);
        reg_read(REG_LIVE_ADR, data);
        expect_value("reg_rdata_o", 32'd0, 32'(data));
        reg_read(REG_TRAIN_ADR, data);
        expect_value("reg_rdata_o", 32'd0, 32'(data));
        reg_read(REG_CTRL_ADR, data);
        expect_value("reg_rdata_o", 32'h7f, 32'(data));
        reg_read(REG_FORCE_ADR, data);
        expect_value("reg_rdata_o", 32'd0, 32'(data));
        for (row = 0; row < NUM_ROWS; row++) begin
            run_row(SCENARIOS[row], row);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
common/surf_link_pkg.sv
surf_live/surf_status_sync.sv
surf_live/surf_live_detector.sv
source/surf_autostart_ctrl.sv
source/surf_link_regs.sv
source/surf_link_top.sv
verif/surf_link_tb.sv
